//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_pic_copy -f sim.f -o Vtb_pic_copy

run: compile
	@out="$$(./obj_dir/Vtb_pic_copy)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

//--- common/pic_defs.svh
// widths, frame buffer size and register offsets, included by the package and by the RTL
`ifndef PIC_DEFS_SVH
`define PIC_DEFS_SVH

////////////////////////////////////////
// data path widths
////////////////////////////////////////

`define PIC_ADDR_W   20   // image memory and frame buffer address
`define PIX_W        8    // one grey pixel

// frame buffer side is 1 << FB_DIM_LOG2
`define FB_DIM_LOG2  8

////////////////////////////////////////
// register bus
////////////////////////////////////////

`define AXIL_ADDR_W  4
`define AXIL_DATA_W  32

// register offsets
`define REG_CTRL     4'h0   // start and mode
`define REG_PIC_BASE 4'h4   // picture base in image memory
`define REG_FB_BASE  4'h8   // frame buffer base
`define REG_STATUS   4'hC   // busy and done

`endif

//--- common/pic_pkg.sv
// shared types of the picture copy engine, imported by the RTL modules and the testbench
`default_nettype none

`include "pic_defs.svh"

package pic_pkg;

	// one-hot source size, anything else is invalid
	typedef enum logic [2:0] {
		MODE_128 = 3'b001,
		MODE_256 = 3'b010,
		MODE_512 = 3'b100
	} pic_mode_t;

	typedef struct packed {
		logic [`PIC_ADDR_W-1:0] pic_base;
		logic [`PIC_ADDR_W-1:0] fb_base;
		pic_mode_t              mode;
	} pic_cfg_t;

	typedef struct packed {
		logic                   valid;
		logic [`PIC_ADDR_W-1:0] addr;
	} img_rd_t;

	typedef struct packed {
		logic                   valid;
		logic [`PIC_ADDR_W-1:0] addr;
		logic [`PIX_W-1:0]      data;
	} fb_wr_t;

	// rides along with each image read
	typedef struct packed {
		logic                   grp_end;  // read closes an output pixel
		logic                   last;     // final output pixel
		logic                   avg;      // 2x2 averaging
		logic [`PIC_ADDR_W-1:0] fb_addr;
	} scan_tag_t;

	typedef struct packed {
		logic                    awvalid;
		logic [`AXIL_ADDR_W-1:0] awaddr;
		logic                    wvalid;
		logic [`AXIL_DATA_W-1:0] wdata;
		logic [`AXIL_DATA_W/8-1:0] wstrb;
		logic                    bready;
		logic                    arvalid;
		logic [`AXIL_ADDR_W-1:0] araddr;
		logic                    rready;
	} axil_req_t;

	typedef struct packed {
		logic                    awready;
		logic                    wready;
		logic                    bvalid;
		logic [1:0]              bresp;
		logic                    arready;
		logic                    rvalid;
		logic [`AXIL_DATA_W-1:0] rdata;
		logic [1:0]              rresp;
	} axil_rsp_t;

endpackage

`default_nettype wire

//--- hw/pic_copy_top.sv
// top of the picture copy engine, joining the register block and the scaler to the memory ports
`timescale 1ns/1ps
`default_nettype none

`include "pic_defs.svh"

module pic_copy_top (
	input  logic               clk,
	input  logic               reset,
	input  pic_pkg::axil_req_t i_axil,
	output pic_pkg::axil_rsp_t o_axil,
	output pic_pkg::img_rd_t   o_img_rd,
	input  logic [`PIX_W-1:0]  i_img_data,
	output pic_pkg::fb_wr_t    o_fb_wr
);
	import pic_pkg::*;

	pic_cfg_t  cfg;    // held while busy
	logic      start;
	logic      done;
	scan_tag_t tag;

	pic_regs pic_regs_inst (
		.clk     (clk),
		.reset   (reset),
		.i_axil  (i_axil),
		.o_axil  (o_axil),
		.o_cfg   (cfg),
		.o_start (start),
		.i_done  (done)
	);

	////////////////////////////////////////
	// scaler
	////////////////////////////////////////

	scan_ctrl scan_ctrl_inst (
		.clk      (clk),
		.reset    (reset),
		.i_cfg    (cfg),
		.i_start  (start),
		.o_img_rd (o_img_rd),
		.o_tag    (tag)
	);

	pixel_merge pixel_merge_inst (
		.clk        (clk),
		.reset      (reset),
		.i_tag      (tag),
		.i_img_data (i_img_data),  // one cycle after the read
		.o_fb_wr    (o_fb_wr),
		.o_done     (done)
	);

endmodule

`default_nettype wire

//--- hw/pic_regs/pic_regs.sv
// AXI4-Lite register block holding the copy configuration, start pulse and busy/done status
`timescale 1ns/1ps
`default_nettype none

`include "pic_defs.svh"

module pic_regs (
	input  logic               clk,
	input  logic               reset,
	input  pic_pkg::axil_req_t i_axil,
	output pic_pkg::axil_rsp_t o_axil,
	output pic_pkg::pic_cfg_t  o_cfg,
	output logic               o_start,
	input  logic               i_done
);
	import pic_pkg::*;

	logic                    wr_acc;
	logic                    rd_acc;
	logic                    bvalid;
	logic                    rvalid;
	logic [`AXIL_DATA_W-1:0] rdata;
	logic [`AXIL_DATA_W-1:0] rd_mux;
	logic [`PIC_ADDR_W-1:0]  pic_base;
	logic [`PIC_ADDR_W-1:0]  fb_base;
	pic_mode_t               mode;
	logic                    busy;
	logic                    done;
	logic [2:0]              wr_mode;
	logic                    mode_ok;
	logic                    ctrl_wr;
	logic                    start_ok;
	logic                    pic_base_wr;
	logic                    fb_base_wr;
	logic [`AXIL_DATA_W-1:0] pic_base_mrg;
	logic [`AXIL_DATA_W-1:0] fb_base_mrg;

	// byte lane merge of a write into an existing register value
	function automatic logic [`AXIL_DATA_W-1:0] merge_strb(
		input logic [`AXIL_DATA_W-1:0]   old_v,
		input logic [`AXIL_DATA_W-1:0]   new_v,
		input logic [`AXIL_DATA_W/8-1:0] strb
	);
		logic [`AXIL_DATA_W-1:0] res;
		res = old_v;
		for (int i = 0; i < `AXIL_DATA_W/8; i++) begin
			if (strb[i])
				res[8*i +: 8] = new_v[8*i +: 8];
		end
		return res;
	endfunction

	////////////////////////////////////////
	// write decode
	////////////////////////////////////////

	assign wr_acc  = i_axil.awvalid & i_axil.wvalid & ~bvalid;  // held bvalid blocks
	assign rd_acc  = i_axil.arvalid & ~rvalid;
	assign wr_mode = i_axil.wdata[3:1];
	assign mode_ok = (wr_mode == MODE_128) || (wr_mode == MODE_256) || (wr_mode == MODE_512);

	assign ctrl_wr     = wr_acc && !busy && (i_axil.awaddr == `REG_CTRL) && i_axil.wstrb[0] && mode_ok;
	assign start_ok    = ctrl_wr && i_axil.wdata[0];
	assign pic_base_wr = wr_acc && !busy && (i_axil.awaddr == `REG_PIC_BASE);
	assign fb_base_wr  = wr_acc && !busy && (i_axil.awaddr == `REG_FB_BASE);

	assign pic_base_mrg = merge_strb(`AXIL_DATA_W'(pic_base), i_axil.wdata, i_axil.wstrb);
	assign fb_base_mrg  = merge_strb(`AXIL_DATA_W'(fb_base), i_axil.wdata, i_axil.wstrb);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pic_base <= '0;
			fb_base  <= '0;
			mode     <= MODE_256;
		end else begin
			if (ctrl_wr)
				mode <= pic_mode_t'(wr_mode);
			if (pic_base_wr)
				pic_base <= pic_base_mrg[`PIC_ADDR_W-1:0];
			if (fb_base_wr)
				fb_base <= fb_base_mrg[`PIC_ADDR_W-1:0];
		end
	end

	// start is self clearing, done waits for the last frame buffer write
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_start <= 1'b0;
			busy    <= 1'b0;
			done    <= 1'b0;
		end else begin
			o_start <= start_ok;
			if (start_ok) begin
				busy <= 1'b1;
				done <= 1'b0;
			end else if (i_done) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// responses
	////////////////////////////////////////

	always_comb begin
		case (i_axil.araddr)
			`REG_CTRL:     rd_mux = `AXIL_DATA_W'({mode, 1'b0});
			`REG_PIC_BASE: rd_mux = `AXIL_DATA_W'(pic_base);
			`REG_FB_BASE:  rd_mux = `AXIL_DATA_W'(fb_base);
			`REG_STATUS:   rd_mux = `AXIL_DATA_W'({done, busy});
			default:       rd_mux = '0;  // unmapped
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (wr_acc)
				bvalid <= 1'b1;
			else if (i_axil.bready)
				bvalid <= 1'b0;
			if (rd_acc)
				rvalid <= 1'b1;
			else if (i_axil.rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_acc)
			rdata <= rd_mux;
	end

	always_comb begin
		o_axil.awready = wr_acc;  // aw and w accepted together
		o_axil.wready  = wr_acc;
		o_axil.bvalid  = bvalid;
		o_axil.bresp   = 2'b00;
		o_axil.arready = rd_acc;
		o_axil.rvalid  = rvalid;
		o_axil.rdata   = rdata;
		o_axil.rresp   = 2'b00;
	end

	assign o_cfg = '{pic_base: pic_base, fb_base: fb_base, mode: mode};

	// every write response belongs to a write taken the cycle before
	a_bvalid_after_write: assert property (@(posedge clk) disable iff (reset)
		$rose(bvalid) |-> $past(wr_acc));

endmodule

`default_nettype wire

//--- hw/pic_scaler/pixel_merge.sv
// lines returned image data up with its tag, averages 2x2 groups and drives frame buffer writes
`timescale 1ns/1ps
`default_nettype none

`include "pic_defs.svh"

module pixel_merge (
	input  logic               clk,
	input  logic               reset,
	input  pic_pkg::scan_tag_t i_tag,
	input  logic [`PIX_W-1:0]  i_img_data,
	output pic_pkg::fb_wr_t    o_fb_wr,
	output logic               o_done
);
	import pic_pkg::*;

	scan_tag_t              tag_q;     // tag of the read whose data is on i_img_data
	logic [`PIX_W+1:0]      sum;       // partial sum of up to three pixels
	logic [`PIX_W+1:0]      sum_all;
	logic                   wr_valid;
	logic [`PIC_ADDR_W-1:0] wr_addr;
	logic [`PIX_W-1:0]      wr_data;

	assign sum_all = sum + {2'b00, i_img_data};

	////////////////////////////////////////
	// tag delay and accumulate
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tag_q    <= '0;
			sum      <= '0;
			wr_valid <= 1'b0;
			o_done   <= 1'b0;
		end else begin
			tag_q <= i_tag;
			if (tag_q.avg)
				sum <= tag_q.grp_end ? '0 : sum_all;  // restart for the next group
			wr_valid <= tag_q.grp_end;
			o_done   <= tag_q.grp_end & tag_q.last;  // together with the last write
		end
	end

	always_ff @(posedge clk) begin
		if (tag_q.grp_end) begin
			wr_addr <= tag_q.fb_addr;
			wr_data <= tag_q.avg ? sum_all[`PIX_W+1:2] : i_img_data;  // divide by 4, floor
		end
	end

	assign o_fb_wr.valid = wr_valid;
	assign o_fb_wr.addr  = wr_addr;
	assign o_fb_wr.data  = wr_data;

	// each write closes a group read two cycles earlier by the scan controller
	a_write_after_group: assert property (@(posedge clk) disable iff (reset)
		o_fb_wr.valid |-> $past(i_tag.grp_end, 2));

endmodule

`default_nettype wire

//--- hw/pic_scaler/scan_ctrl.sv
// raster scan of the 256x256 output issuing image reads and frame buffer tags, used in the scaler
`timescale 1ns/1ps
`default_nettype none

`include "pic_defs.svh"

module scan_ctrl (
	input  logic               clk,
	input  logic               reset,
	input  pic_pkg::pic_cfg_t  i_cfg,
	input  logic               i_start,
	output pic_pkg::img_rd_t   o_img_rd,
	output pic_pkg::scan_tag_t o_tag
);
	import pic_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_SCAN
	} state_t;

	state_t                  state;
	logic [`FB_DIM_LOG2-1:0] row;      // output row
	logic [`FB_DIM_LOG2-1:0] col;      // output column
	logic [1:0]              sub;      // read within a 2x2 group
	logic                    scan;
	logic                    avg;
	logic                    grp_end;
	logic                    last;
	logic [`PIC_ADDR_W-1:0]  img_off;

	assign scan    = (state == ST_SCAN);
	assign avg     = (i_cfg.mode == MODE_512);
	assign grp_end = !avg || (sub == 2'd3);  // single read per pixel unless averaging
	assign last    = grp_end && (&row) && (&col);

	////////////////////////////////////////
	// state and counters
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_IDLE;
			row   <= '0;
			col   <= '0;
			sub   <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_start) begin
						state <= ST_SCAN;
						row   <= '0;
						col   <= '0;
						sub   <= '0;
					end
				end
				ST_SCAN: begin
					sub <= grp_end ? 2'd0 : sub + 2'd1;
					if (grp_end) begin
						col <= col + `FB_DIM_LOG2'd1;  // wraps into the next row
						if (&col)
							row <= row + `FB_DIM_LOG2'd1;
						if (last)
							state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// address forming
	////////////////////////////////////////

	// source offset is row * width + col, built by concatenation
	always_comb begin
		case (i_cfg.mode)
			MODE_128: img_off = `PIC_ADDR_W'({row[`FB_DIM_LOG2-1:1], col[`FB_DIM_LOG2-1:1]});
			MODE_512: img_off = `PIC_ADDR_W'({row, sub[1], col, sub[0]});
			default:  img_off = `PIC_ADDR_W'({row, col});
		endcase
	end

	assign o_img_rd.valid = scan;
	assign o_img_rd.addr  = i_cfg.pic_base + img_off;  // wraps at 20 bits

	assign o_tag.grp_end = scan & grp_end;
	assign o_tag.last    = scan & last;
	assign o_tag.avg     = scan & avg;
	assign o_tag.fb_addr = i_cfg.fb_base + `PIC_ADDR_W'({row, col});

	// the size mode comes from the register block and must stay legal for a whole scan
	a_mode_onehot: assert property (@(posedge clk) disable iff (reset)
		scan |-> $onehot(i_cfg.mode));

	// a read burst only opens right after a start pulse
	a_read_after_start: assert property (@(posedge clk) disable iff (reset)
		$rose(o_img_rd.valid) |-> $past(i_start));

endmodule

`default_nettype wire

//--- sim.f
+incdir+common
common/pic_pkg.sv
hw/pic_regs/pic_regs.sv
hw/pic_scaler/scan_ctrl.sv
hw/pic_scaler/pixel_merge.sv
hw/pic_copy_top.sv
tb/pic_checker.sv
tb/tb_pic_copy.sv

//--- tb/pic_checker.sv
// testbench checker, compares frame buffer writes and register reads against the copy rules
`timescale 1ns/1ps
`default_nettype none

`include "pic_defs.svh"

module pic_checker (
	input  logic                    clk,
	input  pic_pkg::fb_wr_t         i_fb_wr,
	input  pic_pkg::pic_cfg_t       i_cfg,      // config of the running test
	input  logic [63:0]             i_name,
	input  logic                    i_arm,      // restarts the raster count
	input  logic                    i_cmp,
	input  logic [`AXIL_DATA_W-1:0] i_cmp_exp,
	input  logic [`AXIL_DATA_W-1:0] i_cmp_act,
	output int                      o_wr_count,
	output int                      o_wr_total,
	output int                      o_err_count
);
	import pic_pkg::*;

	localparam int N_PIX = 1 << (2 * `FB_DIM_LOG2);

	int wr_count = 0;   // writes of the current copy
	int wr_total = 0;
	int err_count = 0;

	// content of the image memory model
	function automatic logic [`PIX_W-1:0] pixel_at(input logic [`PIC_ADDR_W-1:0] a);
		return a[7:0] ^ a[15:8] ^ {4'h0, a[19:16]};
	endfunction

	function automatic int src_pixel(input pic_cfg_t cfg, input int y, input int x, input int w);
		return int'(pixel_at(cfg.pic_base + `PIC_ADDR_W'(y * w + x)));
	endfunction

	// pixel n of the output raster
	function automatic int expected_pixel(input pic_cfg_t cfg, input int n);
		int r;
		int c;
		int p;
		r = n / 256;
		c = n % 256;
		case (cfg.mode)
			MODE_128: p = src_pixel(cfg, r / 2, c / 2, 128);
			MODE_512: p = (src_pixel(cfg, 2*r, 2*c, 512) + src_pixel(cfg, 2*r, 2*c+1, 512)
				+ src_pixel(cfg, 2*r+1, 2*c, 512) + src_pixel(cfg, 2*r+1, 2*c+1, 512)) / 4;
			default:  p = src_pixel(cfg, r, c, 256);
		endcase
		return p;
	endfunction

	always @(posedge clk) begin
		int                     errs;
		logic [`PIC_ADDR_W-1:0] exp_addr;
		logic [`PIX_W-1:0]      exp_data;
		errs = 0;
		if (i_arm) begin
			wr_count <= 0;
		end else if (i_fb_wr.valid) begin
			if (wr_count >= N_PIX) begin
				$display("unexpected frame buffer write to 0x%05h during %0s", i_fb_wr.addr, i_name);
				errs++;
			end else begin
				exp_addr = i_cfg.fb_base + `PIC_ADDR_W'(wr_count);
				exp_data = `PIX_W'(expected_pixel(i_cfg, wr_count));
				if (i_fb_wr.addr !== exp_addr) begin
					$display("ERR %0s write %0d addr expected 0x%05h actual 0x%05h",
						i_name, wr_count, exp_addr, i_fb_wr.addr);
					errs++;
				end
				if (i_fb_wr.data !== exp_data) begin
					$display("ERR %0s write %0d data expected 0x%02h actual 0x%02h",
						i_name, wr_count, exp_data, i_fb_wr.data);
					errs++;
				end
			end
			wr_count <= wr_count + 1;
			wr_total <= wr_total + 1;
		end
		if (i_cmp && i_cmp_act !== i_cmp_exp) begin  // register or count check from the top
			$display("ERR %0s expected 0x%08h actual 0x%08h", i_name, i_cmp_exp, i_cmp_act);
			errs++;
		end
		err_count <= err_count + errs;
	end

	assign o_wr_count  = wr_count;
	assign o_wr_total  = wr_total;
	assign o_err_count = err_count;

endmodule

`default_nettype wire

//--- tb/tb_pic_copy.sv
// testbench top for the picture copy engine, runs a table of copies through the register bus
`timescale 1ns/1ps
`default_nettype none

`include "pic_defs.svh"

module tb_pic_copy;
	import pic_pkg::*;

	localparam int N_STIM     = 5;
	localparam int FRAME_PIX  = 256 * 256;
	localparam int AXI_LIMIT  = 20;       // cycles for one bus response
	localparam int POLL_LIMIT = 200000;   // status reads before a copy counts as hung

	typedef struct packed {
		logic [63:0]            name;
		logic [2:0]             mode;
		logic [`PIC_ADDR_W-1:0] pic_base;
		logic [`PIC_ADDR_W-1:0] fb_base;
		logic                   copy;     // a copy is expected
	} stim_t;

	logic                    clk;
	logic                    reset;
	axil_req_t               axil_req;
	axil_rsp_t               axil_rsp;
	img_rd_t                 img_rd;
	logic [`PIX_W-1:0]       img_data = '0;
	fb_wr_t                  fb_wr;
	pic_cfg_t                chk_cfg;
	logic [63:0]             chk_name;
	logic                    chk_arm;
	logic                    chk_cmp;
	logic [`AXIL_DATA_W-1:0] chk_exp;
	logic [`AXIL_DATA_W-1:0] chk_act;
	int                      wr_count;
	int                      wr_total;
	int                      err_count;
	stim_t                   stim [N_STIM];
	logic [31:0]             lcg_state;
	logic [`PIC_ADDR_W-1:0]  rd_addr_q = '0;
	logic                    rd_valid_q = 1'b0;
	int                      timeouts;
	bit                      aborted;

	pic_copy_top pic_copy_top_inst (
		.clk        (clk),
		.reset      (reset),
		.i_axil     (axil_req),
		.o_axil     (axil_rsp),
		.o_img_rd   (img_rd),
		.i_img_data (img_data),
		.o_fb_wr    (fb_wr)
	);

	pic_checker pic_checker_inst (
		.clk         (clk),
		.i_fb_wr     (fb_wr),
		.i_cfg       (chk_cfg),
		.i_name      (chk_name),
		.i_arm       (chk_arm),
		.i_cmp       (chk_cmp),
		.i_cmp_exp   (chk_exp),
		.i_cmp_act   (chk_act),
		.o_wr_count  (wr_count),
		.o_wr_total  (wr_total),
		.o_err_count (err_count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [`PIX_W-1:0] pixel_at(input logic [`PIC_ADDR_W-1:0] a);
		return a[7:0] ^ a[15:8] ^ {4'h0, a[19:16]};
	endfunction

	// image memory, data for a read shows up in the next cycle
	always @(negedge clk) begin
		img_data   = rd_valid_q ? pixel_at(rd_addr_q) : ~pixel_at(rd_addr_q);  // junk if no read
		rd_valid_q = img_rd.valid;
		rd_addr_q  = img_rd.addr;
	end

	////////////////////////////////////////
	// bus tasks, all entered just after a falling edge
	////////////////////////////////////////

	task automatic axil_write(input logic [`AXIL_ADDR_W-1:0] addr, input logic [31:0] data);
		int waited;
		if (!aborted) begin
			axil_req.awvalid = 1'b1;
			axil_req.wvalid  = 1'b1;
			axil_req.awaddr  = addr;
			axil_req.wdata   = data;
			waited = 0;
			do begin
				@(negedge clk);
				waited++;
			end while (!axil_rsp.bvalid && waited < AXI_LIMIT);
			axil_req.awvalid = 1'b0;
			axil_req.wvalid  = 1'b0;
			if (!axil_rsp.bvalid) begin
				$display("timeout: no write response for register 0x%0h", addr);
				timeouts++;
				aborted = 1'b1;
			end else begin
				check_value(32'h0, 32'(axil_rsp.bresp));  // OKAY
			end
		end
	endtask

	task automatic axil_read(input logic [`AXIL_ADDR_W-1:0] addr, output logic [31:0] data);
		int waited;
		data = '0;
		if (!aborted) begin
			axil_req.arvalid = 1'b1;
			axil_req.araddr  = addr;
			waited = 0;
			do begin
				@(negedge clk);
				waited++;
			end while (!axil_rsp.rvalid && waited < AXI_LIMIT);
			axil_req.arvalid = 1'b0;
			if (axil_rsp.rvalid) begin
				data = axil_rsp.rdata;
				check_value(32'h0, 32'(axil_rsp.rresp));
			end else begin
				$display("timeout: no read data for register 0x%0h", addr);
				timeouts++;
				aborted = 1'b1;
			end
		end
	endtask

	task automatic check_value(input logic [31:0] exp, input logic [31:0] act);
		chk_exp = exp;
		chk_act = act;
		chk_cmp = 1'b1;
		@(negedge clk);
		chk_cmp = 1'b0;
	endtask

	task automatic arm_checker();
		chk_arm = 1'b1;
		@(negedge clk);
		chk_arm = 1'b0;
	endtask

	task automatic wait_done();
		logic [31:0] rd;
		int          polls;
		rd = '0;
		polls = 0;
		while (!aborted && rd[1:0] != 2'b10) begin  // done set, busy clear
			if (polls == POLL_LIMIT) begin
				$display("timeout: copy %0s never reported done", chk_name);
				timeouts++;
				aborted = 1'b1;
			end else begin
				axil_read(`REG_STATUS, rd);
				polls++;
			end
		end
	endtask

	task automatic run_entry(input stim_t s);
		logic [31:0] rd;
		logic [31:0] status_before;
		int          total_before;
		chk_name = s.name;
		chk_cfg  = '{pic_base: s.pic_base, fb_base: s.fb_base, mode: pic_mode_t'(s.mode)};
		axil_write(`REG_PIC_BASE, 32'(s.pic_base));
		axil_write(`REG_FB_BASE, 32'(s.fb_base));
		axil_read(`REG_PIC_BASE, rd);
		check_value(32'(s.pic_base), rd);
		axil_read(`REG_FB_BASE, rd);
		check_value(32'(s.fb_base), rd);
		if (s.copy) begin
			arm_checker();
			axil_write(`REG_CTRL, {28'h0, s.mode, 1'b1});
			axil_read(`REG_CTRL, rd);
			check_value({28'h0, s.mode, 1'b0}, rd);
			axil_read(`REG_STATUS, rd);
			check_value(32'h1, rd);                     // busy, old done cleared
			axil_write(`REG_PIC_BASE, 32'(~s.pic_base)); // ignored while busy
			axil_read(`REG_PIC_BASE, rd);
			check_value(32'(s.pic_base), rd);
			wait_done();
			check_value(32'(FRAME_PIX), 32'(wr_count));
			axil_read(`REG_STATUS, rd);
			check_value(32'h2, rd);
		end else begin
			axil_read(`REG_STATUS, status_before);
			total_before = wr_total;
			axil_write(`REG_CTRL, {28'h0, s.mode, 1'b1});
			repeat (200) @(negedge clk);
			check_value(32'(total_before), 32'(wr_total));
			axil_read(`REG_STATUS, rd);
			check_value(status_before, rd);
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		logic [31:0] rd;
		reset           = 1'b1;
		axil_req        = '0;
		axil_req.wstrb  = 4'hf;
		axil_req.bready = 1'b1;   // responses taken as soon as they show up
		axil_req.rready = 1'b1;
		chk_cfg         = '0;
		chk_name        = "post_rst";
		chk_arm         = 1'b0;
		chk_cmp         = 1'b0;
		chk_exp         = '0;
		chk_act         = '0;
		timeouts        = 0;
		aborted         = 1'b0;

		stim[0] = '{"copy_256", 3'b010, 20'h00000, 20'h10000, 1'b1};
		stim[1] = '{"copy_128", 3'b001, 20'h20000, 20'h00000, 1'b1};
		lcg_state = lcg_next(32'h1bda3a92);
		stim[2] = '{"copy_512", 3'b100, lcg_state[31:12] | 20'hc0000, 20'h00000, 1'b1};
		lcg_state = lcg_next(lcg_state);
		stim[2].fb_base = lcg_state[31:12] | 20'hf0000;  // near the top so both sides wrap
		stim[3] = '{"bad_mode", 3'b011, 20'h01234, 20'h05678, 1'b0};
		stim[4] = '{"copy_2nd", 3'b010, 20'h5a5a5, 20'hfff00, 1'b1};

		repeat (8) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		axil_read(`REG_STATUS, rd);
		check_value(32'h0, rd);

		for (int i = 0; i < N_STIM && !aborted; i++)
			run_entry(stim[i]);

		repeat (4) @(negedge clk);
		$display("writes %0d, errors %0d, timeouts %0d", wr_total, err_count, timeouts);
		if (err_count == 0 && timeouts == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire
